// ==== logic/ifid_pkg.sv ====
package ifid_pkg;

	localparam int WORD_W = 32;
	localparam int OP_W = 5;
	localparam int REG_AW = 4;
	localparam int IMM_W = 16;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [REG_AW-1:0] reg_addr_t;

	// register form, rb[2:0] doubles as the branch condition.
	typedef struct packed {
		logic [2:0] itype;
		logic [OP_W-1:0] op;
		reg_addr_t wc;
		reg_addr_t ra;
		reg_addr_t rb;
		logic [11:0] unused;
	} instr_reg_t;

	typedef struct packed {
		logic [2:0] itype;
		logic [OP_W-1:0] op;
		reg_addr_t wc;
		reg_addr_t ra;
		logic [IMM_W-1:0] imm;
	} instr_imm_t;

	typedef union packed {
		instr_reg_t r;
		instr_imm_t i;
	} instr_u;

	typedef enum logic [2:0] {
		ALU_REG = 3'd0,
		ALU_IMM = 3'd1,
		LOAD = 3'd2,
		STORE = 3'd3,
		JUMP = 3'd4
	} instr_class_e; // other codes decode as nop.

	typedef enum logic [1:0] {TF_NONE, TF_JUMP_IMM, TF_JUMP_REG} tf_op_e;
	typedef enum logic [1:0] {PC_INC = 2'd0, PC_IMM = 2'd1, PC_REG = 2'd2} pc_sel_e;
	typedef enum logic [1:0] {RB_ALU = 2'd0, RB_MEM = 2'd1, RB_PC = 2'd2} rb_sel_e;

	typedef enum logic [2:0] {
		ALWAYS, ZERO, NOT_ZERO, CARRY, SIGN, OVERFLOW, NOT_SIGN, NEVER
	} cond_e;

	typedef struct packed {
		logic z;
		logic c;
		logic s;
		logic o;
	} flags_t; // z is bit 3.

endpackage

// ==== logic/ctrl_if.sv ====
`timescale 1ns/1ps

interface ctrl_if import ifid_pkg::*; ();

	logic [OP_W-1:0] op_alu;
	logic w_dm;
	logic w_rb;
	rb_sel_e s_mxrb;
	logic s_mxse;
	tf_op_e tf_op;
	word_t imm_ext;

	modport dec (
		output op_alu, w_dm, w_rb, s_mxrb, s_mxse, tf_op, imm_ext
	);

	modport tst (
		input tf_op
	);

	// stage outputs and the jump target.
	modport top (
		input op_alu, w_dm, w_rb, s_mxrb, s_mxse, imm_ext
	);

endinterface

// ==== logic/program_loader.sv ====
`timescale 1ns/1ps

module program_loader #(
	parameter int IMEM_AW = 10
) (
	input logic CLK,
	input logic rst_n,
	input logic load,
	input logic start,
	input logic prog_we,
	output logic [IMEM_AW-1:0] load_addr,
	output logic imem_we,
	output logic run,
	output logic pc_clear
);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_LOAD = 2'd1;
	localparam logic [1:0] ST_RUN = 2'd2;

	logic [1:0] state;

	assign imem_we = (state == ST_LOAD) && prog_we; // writes only while loading.
	assign run = (state == ST_RUN);

	// pc is cleared on the same edge that enters run.
	assign pc_clear = (state == ST_IDLE) && !load && start;

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			load_addr <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (load) begin
						state <= ST_LOAD;
						load_addr <= '0; // every load starts at word 0.
					end else if (start) begin
						state <= ST_RUN;
					end
				end
				ST_LOAD: begin
					if (imem_we)
						load_addr <= load_addr + 1'b1;
					if (!load)
						state <= ST_IDLE;
				end
				ST_RUN: begin
					state <= ST_RUN; // held until reset.
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

// ==== logic/program_counter.sv ====
`timescale 1ns/1ps

module program_counter import ifid_pkg::*; #(
	parameter int IMEM_AW = 10
) (
	input logic CLK,
	input logic rst_n,
	input logic run,
	input logic pc_clear,
	input pc_sel_e pc_sel,
	input word_t imm_ext,
	input word_t prb,
	output logic [IMEM_AW-1:0] pc,
	output word_t pc_next_seq
);

	logic [IMEM_AW-1:0] pc_next;

	// link value, also the fall-through target.
	assign pc_next_seq = {{(WORD_W-IMEM_AW){1'b0}}, pc} + 32'd1;

	always_comb begin
		case (pc_sel)
			PC_IMM: pc_next = imm_ext[IMEM_AW-1:0];
			PC_REG: pc_next = prb[IMEM_AW-1:0];
			default: pc_next = pc_next_seq[IMEM_AW-1:0];
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (pc_clear) begin
			pc <= '0;
		end else if (run) begin
			pc <= pc_next;
		end
	end

endmodule

// ==== logic/instruction_memory.sv ====
`timescale 1ns/1ps

module instruction_memory import ifid_pkg::*; #(
	parameter int IMEM_AW = 10
) (
	input logic CLK,
	input logic we,
	input logic [IMEM_AW-1:0] waddr,
	input logic [IMEM_AW-1:0] raddr,
	input word_t wdata,
	output instr_u instr
);

	localparam int DEPTH = 2 ** IMEM_AW;

	word_t mem [DEPTH];

	always_ff @(posedge CLK) begin
		if (we)
			mem[waddr] <= wdata;
	end

	// asynchronous read at the pc.
	assign instr = mem[raddr];

endmodule

// ==== logic/register_bank.sv ====
`timescale 1ns/1ps

module register_bank import ifid_pkg::*; (
	input logic CLK,
	input logic rst_n,
	input logic w_rb,
	input reg_addr_t wc,
	input reg_addr_t ra,
	input reg_addr_t rb,
	input word_t wpc,
	output word_t pra,
	output word_t prb
);

	localparam int NREGS = 2 ** REG_AW;

	word_t regs [NREGS];

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			for (int i = 0; i < NREGS; i++)
				regs[i] <= '0;
		end else if (w_rb) begin
			regs[wc] <= wpc;
		end
	end

	// no bypass, a same-cycle read sees the old value.
	assign pra = regs[ra];
	assign prb = regs[rb];

endmodule

// ==== logic/control_decoder.sv ====
`timescale 1ns/1ps

module control_decoder import ifid_pkg::*; (
	input instr_u instr,
	ctrl_if.dec ctrl
);

	instr_class_e iclass;
	logic [OP_W-1:0] op;
	logic [IMM_W-1:0] imm;

	assign iclass = instr_class_e'(instr.r.itype);
	assign op = instr.r.op;
	assign imm = instr.i.imm;

	// op[4] picks zero extension.
	assign ctrl.imm_ext = op[4] ? {{(WORD_W-IMM_W){1'b0}}, imm}
		: {{(WORD_W-IMM_W){imm[IMM_W-1]}}, imm};

	always_comb begin
		ctrl.op_alu = '0; // add.
		ctrl.w_dm = 1'b0;
		ctrl.w_rb = 1'b0;
		ctrl.s_mxrb = RB_ALU;
		ctrl.s_mxse = 1'b0;
		ctrl.tf_op = TF_NONE;
		case (iclass)
			ALU_REG: begin
				ctrl.op_alu = op;
				ctrl.w_rb = 1'b1;
			end
			ALU_IMM: begin
				ctrl.op_alu = op;
				ctrl.w_rb = 1'b1;
				ctrl.s_mxse = 1'b1;
			end
			LOAD: begin
				ctrl.w_rb = 1'b1;
				ctrl.s_mxse = 1'b1;
				ctrl.s_mxrb = RB_MEM;
			end
			STORE: begin
				ctrl.w_dm = 1'b1;
				ctrl.s_mxse = 1'b1;
			end
			JUMP: begin
				// op[0] links, op[1] jumps through a register.
				ctrl.w_rb = op[0];
				ctrl.s_mxrb = op[0] ? RB_PC : RB_ALU;
				ctrl.tf_op = op[1] ? TF_JUMP_REG : TF_JUMP_IMM;
			end
			default: begin
				ctrl.tf_op = TF_NONE; // nop.
			end
		endcase
	end

endmodule

// ==== logic/branch_tester.sv ====
`timescale 1ns/1ps

module branch_tester import ifid_pkg::*; (
	input flags_t flags,
	input cond_e cond,
	ctrl_if.tst ctrl,
	output pc_sel_e pc_sel
);

	logic taken;

	always_comb begin
		case (cond)
			ALWAYS: taken = 1'b1;
			ZERO: taken = flags.z;
			NOT_ZERO: taken = !flags.z;
			CARRY: taken = flags.c;
			SIGN: taken = flags.s;
			OVERFLOW: taken = flags.o;
			NOT_SIGN: taken = !flags.s;
			default: taken = 1'b0; // never.
		endcase
	end

	always_comb begin
		pc_sel = PC_INC;
		if (taken) begin
			if (ctrl.tf_op == TF_JUMP_IMM)
				pc_sel = PC_IMM;
			else if (ctrl.tf_op == TF_JUMP_REG)
				pc_sel = PC_REG;
		end
	end

endmodule

// ==== logic/if_id_stage.sv ====
`timescale 1ns/1ps

module if_id_stage import ifid_pkg::*; #(
	parameter int IMEM_AW = 10
) (
	input logic CLK,
	input logic rst_n,
	input logic load,
	input logic start,
	input logic prog_we,
	input logic [31:0] prog_data,
	input logic [3:0] flags,
	input logic [31:0] wpc,
	input logic w_rb_in,
	output logic [3:0] ra,
	output logic [3:0] rb,
	output logic [3:0] wc,
	output logic [31:0] pc_out,
	output logic [31:0] pra,
	output logic [31:0] prb,
	output logic [31:0] se_out,
	output logic [4:0] op_alu,
	output logic s_mxse,
	output logic w_dm,
	output logic w_rb,
	output logic [1:0] s_mxrb
);

	logic [IMEM_AW-1:0] load_addr;
	logic [IMEM_AW-1:0] pc;
	logic imem_we;
	logic run;
	logic pc_clear;
	pc_sel_e pc_sel;
	instr_u instr;

	ctrl_if ctrl ();

	assign ra = instr.r.ra;
	assign rb = instr.r.rb;
	assign wc = instr.r.wc;
	assign se_out = ctrl.imm_ext;
	assign op_alu = ctrl.op_alu;
	assign s_mxse = ctrl.s_mxse;
	assign w_dm = ctrl.w_dm;
	assign w_rb = ctrl.w_rb;
	assign s_mxrb = ctrl.s_mxrb;

	program_loader #(.IMEM_AW(IMEM_AW)) u_loader (
		.CLK(CLK), .rst_n(rst_n), .load(load), .start(start), .prog_we(prog_we),
		.load_addr(load_addr), .imem_we(imem_we), .run(run), .pc_clear(pc_clear)
	);

	program_counter #(.IMEM_AW(IMEM_AW)) u_pc (
		.CLK(CLK), .rst_n(rst_n), .run(run), .pc_clear(pc_clear), .pc_sel(pc_sel),
		.imm_ext(ctrl.imm_ext), .prb(prb), .pc(pc), .pc_next_seq(pc_out)
	);

	instruction_memory #(.IMEM_AW(IMEM_AW)) u_imem (
		.CLK(CLK), .we(imem_we), .waddr(load_addr), .raddr(pc),
		.wdata(prog_data), .instr(instr)
	);

	register_bank u_regs (
		.CLK(CLK), .rst_n(rst_n), .w_rb(w_rb_in), .wc(instr.r.wc), .ra(instr.r.ra),
		.rb(instr.r.rb), .wpc(wpc), .pra(pra), .prb(prb)
	);

	control_decoder u_dec (.instr(instr), .ctrl(ctrl.dec));

	branch_tester u_tf (
		.flags(flags_t'(flags)), .cond(cond_e'(instr.r.rb[2:0])),
		.ctrl(ctrl.tst), .pc_sel(pc_sel)
	);

endmodule

// ==== tests/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen #(
	parameter int PERIOD = 40,
	parameter int RST_CYCLES = 16
) (
	output logic CLK,
	output logic rst_n
);

	initial begin
		CLK = 1'b0;
		forever #(PERIOD / 2) CLK = ~CLK;
	end

	// release on a falling edge, clear of the sampling edge.
	initial begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge CLK);
		@(negedge CLK);
		rst_n = 1'b1;
	end

endmodule

// ==== tests/tb_if_id.sv ====
`timescale 1ns/1ps

module tb_if_id import ifid_pkg::*; ();

	localparam int PERIOD = 40;
	localparam int RST_CYCLES = 16;
	localparam int PROG_BASE = 'h10;
	localparam int VEC_BASE = 'h40;
	localparam int VEC_W = 13; // words per run vector.

	logic CLK, rst_n;
	logic load, start, prog_we, w_rb_in;
	logic [31:0] prog_data, wpc;
	logic [3:0] flags;
	logic [3:0] ra, rb, wc;
	logic [31:0] pc_out, pra, prb, se_out;
	logic [4:0] op_alu;
	logic s_mxse, w_dm, w_rb;
	logic [1:0] s_mxrb;

	logic [31:0] test_data [512];
	word_t shadow [16]; // expected register contents.
	logic [31:0] lfsr_state;
	int tests_run, tests_failed, errs;
	int watch_cycles;

	clock_gen #(.PERIOD(PERIOD), .RST_CYCLES(RST_CYCLES)) u_clk (.CLK(CLK), .rst_n(rst_n));

	if_id_stage #(.IMEM_AW(10)) u_dut (
		.CLK(CLK), .rst_n(rst_n), .load(load), .start(start), .prog_we(prog_we),
		.prog_data(prog_data), .flags(flags), .wpc(wpc), .w_rb_in(w_rb_in),
		.ra(ra), .rb(rb), .wc(wc), .pc_out(pc_out), .pra(pra), .prb(prb),
		.se_out(se_out), .op_alu(op_alu), .s_mxse(s_mxse), .w_dm(w_dm), .w_rb(w_rb),
		.s_mxrb(s_mxrb)
	);

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// one lfsr step per bit.
	task automatic draw_word(output word_t w);
		word_t acc;
		acc = '0;
		for (int i = 0; i < 32; i++) begin
			acc = {acc[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		w = acc;
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			errs++;
		end
	endtask

	task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			errs++;
		end
	endtask

	task automatic check_ctrl(
		input logic [OP_W-1:0] op_got, input logic [OP_W-1:0] op_exp,
		input logic wrb_got, input logic wrb_exp,
		input logic wdm_got, input logic wdm_exp,
		input rb_sel_e mxrb_got, input rb_sel_e mxrb_exp,
		input logic mxse_got, input logic mxse_exp
	);
		if (op_got !== op_exp) begin
			$display("Mismatch op_alu: got %h expected %h", op_got, op_exp);
			errs++;
		end
		if (wrb_got !== wrb_exp) begin
			$display("Mismatch w_rb: got %h expected %h", wrb_got, wrb_exp);
			errs++;
		end
		if (wdm_got !== wdm_exp) begin
			$display("Mismatch w_dm: got %h expected %h", wdm_got, wdm_exp);
			errs++;
		end
		if (mxrb_got !== mxrb_exp) begin
			$display("Mismatch s_mxrb: got %h expected %h", mxrb_got, mxrb_exp);
			errs++;
		end
		if (mxse_got !== mxse_exp) begin
			$display("Mismatch s_mxse: got %h expected %h", mxse_got, mxse_exp);
			errs++;
		end
	endtask

	task automatic finish_test(input string label);
		tests_run++;
		if (errs != 0) begin
			tests_failed++;
			$display("%s: fail, %0d errors", label, errs);
		end else begin
			$display("%s: pass", label);
		end
		errs = 0;
	endtask

	task automatic sample_wait();
		#(PERIOD / 2 - 1); // just before the rising edge.
	endtask

	// word 0 is a nop, so all controls read zero while loading.
	task automatic load_program(input int nprog);
		@(negedge CLK);
		sample_wait();
		check_word("pc_out", pc_out, 32'd1);
		@(negedge CLK);
		load = 1'b1;
		sample_wait();
		check_word("pc_out", pc_out, 32'd1);
		for (int k = 0; k < nprog; k++) begin
			@(negedge CLK);
			prog_we = 1'b1;
			prog_data = test_data[PROG_BASE + k];
			sample_wait();
			check_word("pc_out", pc_out, 32'd1);
			if (k > 0)
				check_ctrl(op_alu, '0, w_rb, 1'b0, w_dm, 1'b0, rb_sel_e'(s_mxrb), RB_ALU,
					s_mxse, 1'b0);
		end
		@(negedge CLK);
		prog_we = 1'b0;
		load = 1'b0;
		sample_wait();
		check_word("pc_out", pc_out, 32'd1);
		check_ctrl(op_alu, '0, w_rb, 1'b0, w_dm, 1'b0, rb_sel_e'(s_mxrb), RB_ALU, s_mxse, 1'b0);
		finish_test("test 1 reset and load");
	endtask

	task automatic run_vectors(input int nvec);
		int base;
		logic [31:0] we_mode;
		word_t wval;
		@(negedge CLK);
		start = 1'b1; // pc clears on the edge into run.
		for (int i = 0; i < nvec; i++) begin
			base = VEC_BASE + i * VEC_W;
			@(negedge CLK);
			start = 1'b0;
			flags = test_data[base][3:0];
			we_mode = test_data[base + 2];
			if (we_mode == 2)
				draw_word(wval);
			else
				wval = test_data[base + 1];
			wpc = wval;
			w_rb_in = (we_mode != 0);
			sample_wait();
			check_word("pc_out", pc_out, test_data[base + 3]);
			check_reg("ra", ra, test_data[base + 4][3:0]);
			check_reg("rb", rb, test_data[base + 5][3:0]);
			check_reg("wc", wc, test_data[base + 6][3:0]);
			check_word("se_out", se_out, test_data[base + 7]);
			check_ctrl(op_alu, test_data[base + 8][4:0], w_rb, test_data[base + 9][0],
				w_dm, test_data[base + 10][0], rb_sel_e'(s_mxrb),
				rb_sel_e'(test_data[base + 11][1:0]), s_mxse, test_data[base + 12][0]);
			check_word("pra", pra, shadow[test_data[base + 4][3:0]]);
			check_word("prb", prb, shadow[test_data[base + 5][3:0]]);
			if (w_rb_in)
				shadow[test_data[base + 6][3:0]] = wval; // lands on this edge.
			finish_test($sformatf("vector %0d at pc %0d", i, test_data[base + 3] - 1));
		end
		@(negedge CLK);
		w_rb_in = 1'b0;
	endtask

	initial begin
		wait (watch_cycles > 0);
		#(watch_cycles * PERIOD);
		$display("timeout: the run did not finish within %0d cycles", watch_cycles);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		load = 1'b0;
		start = 1'b0;
		prog_we = 1'b0;
		prog_data = '0;
		flags = '0;
		wpc = '0;
		w_rb_in = 1'b0;
		lfsr_state = 32'habefdf80;
		tests_run = 0;
		tests_failed = 0;
		errs = 0;
		watch_cycles = 0;
		for (int r = 0; r < 16; r++)
			shadow[r] = '0;
		$readmemh("tests/if_id_tests.mem", test_data);
		if ($isunknown(test_data[0]) || $isunknown(test_data[1])) begin
			$display("could not read the program length and vector count from the data file");
			tests_run++;
			tests_failed++;
		end else begin
			watch_cycles = RST_CYCLES + test_data[0] + test_data[1] + 20;
			wait (rst_n === 1'b1);
			load_program(test_data[0]);
			run_vectors(test_data[1]);
		end
		$display("tests run %0d, passed %0d, failed %0d", tests_run,
			tests_run - tests_failed, tests_failed);
		if (tests_failed == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== tests/if_id_tests.mem ====
// header at 00: program length, vector count. program words from 10.
// vectors from 40: flags wpc we pc_out ra rb wc se_out op_alu w_rb w_dm s_mxrb s_mxse
// we: 0 no write, 1 write the wpc column, 2 write an lfsr word.
@0
10 F
@10
E0000000 03123000 2521FFF0 32328001
40438000 70547FFF 80001008 81603009
E0000000 82002000 80007000 82005000
8000400E E0000000 80006000 80000001
@40
0 00000000 0 00000001 0 0 0 00000000 00 0 0 0 0
0 00000000 2 00000002 2 3 1 00003000 03 1 0 0 0
0 0000000A 1 00000003 1 F 2 FFFFFFF0 05 1 0 0 1
0 00000000 0 00000004 2 8 3 00008001 12 1 0 0 1
0 00000000 0 00000005 3 8 4 FFFF8000 00 1 0 1 1
0 00000000 0 00000006 4 7 5 00007FFF 00 0 1 0 1
0 00000000 0 00000007 0 1 0 00001008 00 0 0 0 0
4 00000000 0 00000008 0 3 6 00003009 00 1 0 2 0
0 00000000 0 0000000A 0 2 0 00002000 00 0 0 0 0
F 00000000 0 0000000B 0 7 0 00007000 00 0 0 0 0
E 00000000 0 0000000C 0 5 0 00005000 00 0 0 0 0
2 00000000 0 0000000D 0 4 0 0000400E 00 0 0 0 0
2 00000000 0 0000000F 0 6 0 00006000 00 0 0 0 0
0 00000000 0 00000010 0 0 0 00000001 00 0 0 0 0
0 00000000 0 00000002 2 3 1 00003000 03 1 0 0 0

// ==== flist.f ====
logic/ifid_pkg.sv
logic/ctrl_if.sv
logic/program_loader.sv
logic/program_counter.sv
logic/instruction_memory.sv
logic/register_bank.sv
logic/control_decoder.sv
logic/branch_tester.sv
logic/if_id_stage.sv
tests/clock_gen.sv
tests/tb_if_id.sv

// ==== Bender.yml ====
package:
  name: if_id_stage

sources:
  - logic/ifid_pkg.sv
  - logic/ctrl_if.sv
  - logic/program_loader.sv
  - logic/program_counter.sv
  - logic/instruction_memory.sv
  - logic/register_bank.sv
  - logic/control_decoder.sv
  - logic/branch_tester.sv
  - logic/if_id_stage.sv
  - target: test
    files:
      - tests/clock_gen.sv
      - tests/tb_if_id.sv
